// File: dcache_pkg.sv
package dcache_pkg;

    localparam int OFFSET_BITS = 5;  // 32-byte line
    localparam int BANKS = 8;        // words per line

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // addr[31:5] identifies a line
    typedef logic [31-OFFSET_BITS:0] line_addr_t;

    // word 0 sits in the low bits
    typedef word_t [BANKS-1:0] line_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line;   // full line address
    } tagv_t;

    typedef struct packed {
        logic       valid;
        logic       op;     // 1 = store
        logic [3:0] wstrb;
        word_t      wdata;
        addr_t      addr;
    } cpu_req_t;

    // byte merge of a store into an existing word
    function automatic word_t merge_word(
        input word_t      old_w,
        input word_t      new_w,
        input logic [3:0] strb
    );
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic line_addr_t line_of(input addr_t a);
        return a[31:OFFSET_BITS];
    endfunction

endpackage

// File: bram_sdp.sv
`timescale 1ns/1ps

module bram_sdp #(
    parameter type data_t = logic [31:0],
    parameter int DEPTH = 128,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic [AW-1:0] rd_addr_i,
    output data_t         rd_data_o,
    input  logic          wen_i,
    input  logic [AW-1:0] wr_addr_i,
    input  data_t         wr_data_i
);

    data_t mem [DEPTH];

    // read during write of the same address sees old contents
    always_ff @(posedge clk) begin
        if (wen_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: dcache_way.sv
`timescale 1ns/1ps

module dcache_way
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128,
    localparam int INDEX_BITS = $clog2(NUM_SETS)
) (
    input  logic                  clk,
    input  logic [INDEX_BITS-1:0] rd_index_i,
    input  logic [INDEX_BITS-1:0] wr_index_i,
    input  logic                  line_we_i,
    input  logic                  tag_we_i,
    input  line_t                 wr_line_i,
    input  tagv_t                 wr_tag_i,
    output line_t                 rd_line_o,
    output tagv_t                 rd_tag_o
);

    // one bank per word of the line, all written together
    for (genvar b = 0; b < BANKS; b++) begin : gen_bank
        bram_sdp #(
            .data_t (word_t),
            .DEPTH  (NUM_SETS)
        ) bank_inst (
            .clk       (clk),
            .rd_addr_i (rd_index_i),
            .rd_data_o (rd_line_o[b]),
            .wen_i     (line_we_i),
            .wr_addr_i (wr_index_i),
            .wr_data_i (wr_line_i[b])
        );
    end

    // tag written on refill and init sweep only
    bram_sdp #(
        .data_t (tagv_t),
        .DEPTH  (NUM_SETS)
    ) tagv_inst (
        .clk       (clk),
        .rd_addr_i (rd_index_i),
        .rd_data_o (rd_tag_o),
        .wen_i     (tag_we_i),
        .wr_addr_i (wr_index_i),
        .wr_data_i (wr_tag_i)
    );

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128,
    localparam int INDEX_BITS = $clog2(NUM_SETS)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_req_t              req_i,
    input  logic                  uncache_i,
    output logic                  addr_ok_o,
    output logic                  data_ok_o,
    output word_t                 rdata_o,
    output logic                  cache_miss_o,
    // way interface
    output logic [INDEX_BITS-1:0] rd_index_o,
    output logic [INDEX_BITS-1:0] wr_index_o,
    output logic [1:0]            line_we_o,
    output logic [1:0]            tag_we_o,
    output line_t                 wr_line_o,
    output tagv_t                 wr_tag_o,
    input  line_t [1:0]           rd_line_i,
    input  tagv_t [1:0]           rd_tag_i,
    // line memory port
    output logic                  rd_req_o,
    output addr_t                 rd_addr_o,
    input  logic                  ret_valid_i,
    input  line_t                 ret_data_i,
    output logic                  wr_req_o,
    output addr_t                 wr_addr_o,
    output line_t                 wr_data_o,
    input  logic                  wr_rdy_i,
    // uncached word port
    output logic                  unc_ren_o,
    output logic                  unc_wen_o,
    output addr_t                 unc_addr_o,
    output word_t                 unc_wdata_o,
    output logic [3:0]            unc_wstrb_o,
    input  logic                  unc_rvalid_i,
    input  word_t                 unc_rdata_i,
    input  logic                  unc_bvalid_i
);

    typedef enum logic [2:0] {
        S_INIT,
        S_LOOKUP,
        S_WRITEBACK,
        S_ASKMEM,
        S_RETURN,
        S_UNCACHED
    } state_t;

    state_t state_q, state_d;

    cpu_req_t              req_q;
    logic                  pend_q;      // cached lookup in flight
    logic                  victim_q;
    line_t                 refill_q;
    logic [INDEX_BITS-1:0] init_idx_q;
    logic [NUM_SETS-1:0]   lru_q;       // way to replace next
    logic [NUM_SETS-1:0][1:0] dirty_q;

    logic [INDEX_BITS-1:0] req_idx;
    logic [INDEX_BITS-1:0] new_idx;
    logic [2:0]            word_sel;
    line_addr_t            req_line;
    logic [1:0]            hit;
    logic                  hit_any;
    logic                  hit_way;
    logic                  lookup_hit;
    logic                  lookup_miss;
    logic                  victim;
    logic                  victim_wb;
    logic                  conflict;
    logic                  accept;
    line_t                 hit_line;
    line_t                 base_line;
    word_t                 merged_word;

    assign req_idx  = req_q.addr[OFFSET_BITS +: INDEX_BITS];
    assign new_idx  = req_i.addr[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = req_q.addr[OFFSET_BITS-1:2];
    assign req_line = line_of(req_q.addr);

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = rd_tag_i[w].valid && (rd_tag_i[w].line == req_line);
        end
    end

    assign hit_any     = |hit;
    assign hit_way     = hit[1];
    assign lookup_hit  = (state_q == S_LOOKUP) && pend_q && hit_any;
    assign lookup_miss = (state_q == S_LOOKUP) && pend_q && !hit_any;
    assign victim      = lru_q[req_idx];
    assign victim_wb   = rd_tag_i[victim].valid && dirty_q[req_idx][victim];

    // store hit writes this set now, a read of it would see stale data
    assign conflict  = lookup_hit && req_q.op && (new_idx == req_idx);
    assign accept    = (state_q == S_LOOKUP) && req_i.valid && !lookup_miss && !conflict;
    assign addr_ok_o = accept;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_INIT: begin
                if (init_idx_q == INDEX_BITS'(NUM_SETS - 1)) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (lookup_miss) begin
                    state_d = victim_wb ? S_WRITEBACK : S_ASKMEM;
                end else if (accept && uncache_i) begin
                    state_d = S_UNCACHED;
                end
            end
            S_WRITEBACK: begin
                if (wr_rdy_i) begin
                    state_d = S_ASKMEM;
                end
            end
            S_ASKMEM: begin
                if (ret_valid_i) begin
                    state_d = S_RETURN;
                end
            end
            S_RETURN: begin
                state_d = S_LOOKUP;
            end
            S_UNCACHED: begin
                if (req_q.op ? unc_bvalid_i : unc_rvalid_i) begin
                    state_d = S_LOOKUP;
                end
            end
            default: begin
                state_d = S_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= S_INIT;
            pend_q     <= 1'b0;
            init_idx_q <= '0;
        end else begin
            state_q <= state_d;
            pend_q  <= accept && !uncache_i;
            if (state_q == S_INIT) begin
                init_idx_q <= init_idx_q + 1'b1;  // valid clear sweep
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (lookup_miss) begin
            victim_q <= victim;
        end
        if ((state_q == S_ASKMEM) && ret_valid_i) begin
            refill_q <= ret_data_i;  // only valid for the pulse
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else if (lookup_hit) begin
            lru_q[req_idx] <= !hit_way;
            if (req_q.op) begin
                dirty_q[req_idx][hit_way] <= 1'b1;
            end
        end else if (state_q == S_RETURN) begin
            lru_q[req_idx]             <= !victim_q;
            dirty_q[req_idx][victim_q] <= req_q.op;  // load refill leaves it clean
        end
    end

    // read index follows the new request only when it is taken
    assign rd_index_o = accept ? new_idx : req_idx;
    assign wr_index_o = (state_q == S_INIT) ? init_idx_q : req_idx;

    assign hit_line    = rd_line_i[hit_way];
    assign base_line   = (state_q == S_RETURN) ? refill_q : hit_line;
    assign merged_word = merge_word(base_line[word_sel], req_q.wdata, req_q.wstrb);

    always_comb begin
        wr_line_o = base_line;
        if (req_q.op) begin
            wr_line_o[word_sel] = merged_word;
        end
    end

    assign wr_tag_o = tagv_t'{valid: (state_q != S_INIT), line: req_line};

    always_comb begin
        line_we_o = '0;
        tag_we_o  = '0;
        if (state_q == S_INIT) begin
            tag_we_o = 2'b11;
        end else if (lookup_hit && req_q.op) begin
            line_we_o[hit_way] = 1'b1;  // data only, tag untouched
        end else if (state_q == S_RETURN) begin
            line_we_o[victim_q] = 1'b1;
            tag_we_o[victim_q]  = 1'b1;
        end
    end

    assign data_ok_o = !req_q.op && (lookup_hit || (state_q == S_RETURN) ||
                       ((state_q == S_UNCACHED) && unc_rvalid_i));

    always_comb begin
        case (state_q)
            S_UNCACHED: rdata_o = unc_rdata_i;
            S_RETURN:   rdata_o = refill_q[word_sel];
            default:    rdata_o = hit_line[word_sel];
        endcase
    end

    assign cache_miss_o = lookup_miss || (state_q == S_WRITEBACK) ||
                          (state_q == S_ASKMEM) || (state_q == S_RETURN);

    assign rd_req_o  = (state_q == S_ASKMEM);
    assign rd_addr_o = {req_line, OFFSET_BITS'(0)};

    // set is not rewritten until RETURN, so the way output stays put
    assign wr_req_o  = (state_q == S_WRITEBACK);
    assign wr_addr_o = {rd_tag_i[victim_q].line, OFFSET_BITS'(0)};
    assign wr_data_o = rd_line_i[victim_q];

    assign unc_ren_o   = (state_q == S_UNCACHED) && !req_q.op;
    assign unc_wen_o   = (state_q == S_UNCACHED) && req_q.op;
    assign unc_addr_o  = req_q.addr;
    assign unc_wdata_o = req_q.wdata;
    assign unc_wstrb_o = req_q.wstrb;

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128,
    localparam int INDEX_BITS = $clog2(NUM_SETS)
) (
    input  logic       clk,
    input  logic       reset,
    input  cpu_req_t   req_i,
    input  logic       uncache_i,
    output logic       addr_ok_o,
    output logic       data_ok_o,
    output word_t      rdata_o,
    output logic       cache_miss_o,
    output logic       rd_req_o,
    output addr_t      rd_addr_o,
    input  logic       ret_valid_i,
    input  line_t      ret_data_i,
    output logic       wr_req_o,
    output addr_t      wr_addr_o,
    output line_t      wr_data_o,
    input  logic       wr_rdy_i,
    output logic       unc_ren_o,
    output logic       unc_wen_o,
    output addr_t      unc_addr_o,
    output word_t      unc_wdata_o,
    output logic [3:0] unc_wstrb_o,
    input  logic       unc_rvalid_i,
    input  word_t      unc_rdata_i,
    input  logic       unc_bvalid_i
);

    logic [INDEX_BITS-1:0] rd_index;
    logic [INDEX_BITS-1:0] wr_index;
    logic [1:0]            line_we;
    logic [1:0]            tag_we;
    line_t                 wr_line;
    tagv_t                 wr_tag;
    line_t [1:0]           rd_line;
    tagv_t [1:0]           rd_tag;

    dcache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .req_i        (req_i),
        .uncache_i    (uncache_i),
        .addr_ok_o    (addr_ok_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .cache_miss_o (cache_miss_o),
        .rd_index_o   (rd_index),
        .wr_index_o   (wr_index),
        .line_we_o    (line_we),
        .tag_we_o     (tag_we),
        .wr_line_o    (wr_line),
        .wr_tag_o     (wr_tag),
        .rd_line_i    (rd_line),
        .rd_tag_i     (rd_tag),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .wr_req_o     (wr_req_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .wr_rdy_i     (wr_rdy_i),
        .unc_ren_o    (unc_ren_o),
        .unc_wen_o    (unc_wen_o),
        .unc_addr_o   (unc_addr_o),
        .unc_wdata_o  (unc_wdata_o),
        .unc_wstrb_o  (unc_wstrb_o),
        .unc_rvalid_i (unc_rvalid_i),
        .unc_rdata_i  (unc_rdata_i),
        .unc_bvalid_i (unc_bvalid_i)
    );

    // both ways share indexes and write data, enables are per way
    for (genvar w = 0; w < 2; w++) begin : gen_way
        dcache_way #(
            .NUM_SETS (NUM_SETS)
        ) way_inst (
            .clk        (clk),
            .rd_index_i (rd_index),
            .wr_index_i (wr_index),
            .line_we_i  (line_we[w]),
            .tag_we_i   (tag_we[w]),
            .wr_line_i  (wr_line),
            .wr_tag_i   (wr_tag),
            .rd_line_o  (rd_line[w]),
            .rd_tag_o   (rd_tag[w])
        );
    end

endmodule

// File: dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input cpu_req_t req_i,
    input logic     addr_ok_o,
    input logic     data_ok_o,
    input logic     rd_req_o,
    input logic     wr_req_o,
    input logic     wr_rdy_i,
    input logic     unc_ren_o,
    input logic     unc_wen_o
);

    logic load_pend;  // accepted load still owed a data_ok

    always_ff @(posedge clk) begin
        if (reset) begin
            load_pend <= 1'b0;
        end else if (addr_ok_o && !req_i.op) begin
            load_pend <= 1'b1;
        end else if (data_ok_o) begin
            load_pend <= 1'b0;
        end
    end

    wb_hold: assert property (@(posedge clk) disable iff (reset)
        wr_req_o && !wr_rdy_i |=> wr_req_o)
        else $error("wr_req_o dropped before wr_rdy_i");

    rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(rd_req_o && wr_req_o))
        else $error("rd_req_o and wr_req_o high together");

    data_after_load: assert property (@(posedge clk) disable iff (reset)
        data_ok_o |-> load_pend)
        else $error("data_ok_o without an accepted load");

    unc_excl: assert property (@(posedge clk) disable iff (reset)
        !(unc_ren_o && unc_wen_o))
        else $error("unc_ren_o and unc_wen_o high together");

endmodule

bind dcache_top dcache_assert dcache_assert_inst (.*);

// File: tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rd_req_i,
    input  addr_t      rd_addr_i,
    output logic       ret_valid_o,
    output line_t      ret_data_o,
    input  logic       wr_req_i,
    input  addr_t      wr_addr_i,
    input  line_t      wr_data_i,
    output logic       wr_rdy_o,
    input  logic       unc_ren_i,
    input  logic       unc_wen_i,
    input  addr_t      unc_addr_i,
    input  word_t      unc_wdata_i,
    input  logic [3:0] unc_wstrb_i,
    output logic       unc_rvalid_o,
    output word_t      unc_rdata_o,
    output logic       unc_bvalid_o
);

    logic [7:0] mem [16384];  // 16 KB byte array
    int         wb_count;
    int         rd_count;
    addr_t      last_wb_addr;
    line_t      last_wb_data;

    function automatic word_t read_word(input addr_t a);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        return {mem[base + 14'd3], mem[base + 14'd2], mem[base + 14'd1], mem[base]};
    endfunction

    task automatic write_word(input addr_t a, input word_t d, input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                mem[{a[13:2], 2'(b)}] = d[8*b +: 8];
            end
        end
    endtask

    // one request at a time answered after 1 to 6 cycles
    initial begin
        int   delay;
        logic active;
        ret_valid_o  = 1'b0;
        ret_data_o   = '0;
        wr_rdy_o     = 1'b0;
        unc_rvalid_o = 1'b0;
        unc_rdata_o  = '0;
        unc_bvalid_o = 1'b0;
        wb_count     = 0;
        rd_count     = 0;
        last_wb_addr = '0;
        last_wb_data = '0;
        active       = 1'b0;
        delay        = 0;
        forever begin
            @(negedge clk);
            ret_valid_o  = 1'b0;
            wr_rdy_o     = 1'b0;
            unc_rvalid_o = 1'b0;
            unc_bvalid_o = 1'b0;
            if (rd_req_i || wr_req_i || unc_ren_i || unc_wen_i) begin
                if (!active) begin
                    active = 1'b1;
                    delay  = $urandom_range(5, 0);
                end
                if (delay > 0) begin
                    delay--;
                end else begin
                    active = 1'b0;
                    if (wr_req_i) begin
                        for (int w = 0; w < BANKS; w++) begin
                            write_word(wr_addr_i + 4 * w, wr_data_i[3'(w)], 4'hf);
                        end
                        wb_count++;
                        last_wb_addr = wr_addr_i;
                        last_wb_data = wr_data_i;
                        wr_rdy_o     = 1'b1;
                    end else if (rd_req_i) begin
                        for (int w = 0; w < BANKS; w++) begin
                            ret_data_o[3'(w)] = read_word(rd_addr_i + 4 * w);
                        end
                        rd_count++;
                        ret_valid_o = 1'b1;
                    end else if (unc_wen_i) begin
                        write_word(unc_addr_i, unc_wdata_i, unc_wstrb_i);
                        unc_bvalid_o = 1'b1;
                    end else begin
                        unc_rdata_o  = read_word(unc_addr_i);
                        unc_rvalid_o = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128
);

    localparam int    TIMEOUT = 2000;
    localparam addr_t STRIDE  = NUM_SETS * 32;  // same set, next tag

    logic       clk;
    logic       reset;
    cpu_req_t   req;
    logic       uncache;
    logic       addr_ok;
    logic       data_ok;
    word_t      rdata;
    logic       cache_miss;
    logic       rd_req;
    addr_t      rd_addr;
    logic       ret_valid;
    line_t      ret_data;
    logic       wr_req;
    addr_t      wr_addr;
    line_t      wr_data;
    logic       wr_rdy;
    logic       unc_ren;
    logic       unc_wen;
    addr_t      unc_addr;
    word_t      unc_wdata;
    logic [3:0] unc_wstrb;
    logic       unc_rvalid;
    word_t      unc_rdata;
    logic       unc_bvalid;

    logic [7:0] shadow [16384];  // what memory should hold
    int         n_checks;
    int         n_errors;
    int         n_timeouts;
    word_t      last_rdata;
    int         last_latency;
    int         last_miss;

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) dcache_top_inst (
        .clk          (clk),
        .reset        (reset),
        .req_i        (req),
        .uncache_i    (uncache),
        .addr_ok_o    (addr_ok),
        .data_ok_o    (data_ok),
        .rdata_o      (rdata),
        .cache_miss_o (cache_miss),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .ret_valid_i  (ret_valid),
        .ret_data_i   (ret_data),
        .wr_req_o     (wr_req),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .wr_rdy_i     (wr_rdy),
        .unc_ren_o    (unc_ren),
        .unc_wen_o    (unc_wen),
        .unc_addr_o   (unc_addr),
        .unc_wdata_o  (unc_wdata),
        .unc_wstrb_o  (unc_wstrb),
        .unc_rvalid_i (unc_rvalid),
        .unc_rdata_i  (unc_rdata),
        .unc_bvalid_i (unc_bvalid)
    );

    tb_mem_model mem_model_inst (
        .clk          (clk),
        .rd_req_i     (rd_req),
        .rd_addr_i    (rd_addr),
        .ret_valid_o  (ret_valid),
        .ret_data_o   (ret_data),
        .wr_req_i     (wr_req),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .wr_rdy_o     (wr_rdy),
        .unc_ren_i    (unc_ren),
        .unc_wen_i    (unc_wen),
        .unc_addr_i   (unc_addr),
        .unc_wdata_i  (unc_wdata),
        .unc_wstrb_i  (unc_wstrb),
        .unc_rvalid_o (unc_rvalid),
        .unc_rdata_o  (unc_rdata),
        .unc_bvalid_o (unc_bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t shadow_word(input addr_t a);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        return {shadow[base + 14'd3], shadow[base + 14'd2], shadow[base + 14'd1], shadow[base]};
    endfunction

    function automatic word_t model_word(input addr_t a);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        return {mem_model_inst.mem[base + 14'd3], mem_model_inst.mem[base + 14'd2],
                mem_model_inst.mem[base + 14'd1], mem_model_inst.mem[base]};
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic issue(input logic op, input addr_t addr, input word_t wdata,
                         input logic [3:0] wstrb, input logic unc);
        int cnt;
        req.valid = 1'b1;
        req.op    = op;
        req.wstrb = wstrb;
        req.wdata = wdata;
        req.addr  = addr;
        uncache   = unc;
        cnt       = 0;
        #1;
        while (!addr_ok && n_timeouts == 0) begin
            @(negedge clk);
            #1;
            cnt++;
            if (cnt > TIMEOUT) begin
                n_timeouts++;
                $display("Timeout: request at %h was never accepted", addr);
            end
        end
        @(posedge clk);
        @(negedge clk);
        req.valid = 1'b0;
        uncache   = 1'b0;
        if (op) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    shadow[{addr[13:2], 2'(b)}] = wdata[8*b +: 8];
                end
            end
        end else begin
            cnt       = 0;
            last_miss = 0;
            #1;
            while (!data_ok && n_timeouts == 0) begin
                if (cache_miss) begin
                    last_miss = 1;
                end
                @(negedge clk);
                #1;
                cnt++;
                if (cnt > TIMEOUT) begin
                    n_timeouts++;
                    $display("Timeout: load at %h never returned data", addr);
                end
            end
            if (cache_miss) begin
                last_miss = 1;
            end
            last_latency = cnt + 1;  // cycles after acceptance
            last_rdata   = rdata;
            @(negedge clk);
        end
    endtask

    task automatic store(input addr_t addr, input word_t wdata, input logic [3:0] wstrb);
        issue(1'b1, addr, wdata, wstrb, 1'b0);
    endtask

    task automatic load_check(input string name, input addr_t addr);
        issue(1'b0, addr, '0, 4'h0, 1'b0);
        check(name, shadow_word(addr), last_rdata);
    endtask

    task automatic load_miss_hit_test();
        load_check("load_miss_hit first", 32'h44);
        check("load_miss_hit first miss flag", 1, last_miss);
        load_check("load_miss_hit second", 32'h48);
        check("load_miss_hit latency", 1, last_latency);
        check("load_miss_hit second miss flag", 0, last_miss);
    endtask

    task automatic store_merge_test();
        load_check("store_merge fill", 32'h88);
        store(32'h88, 32'ha1b2c3d4, 4'b0101);
        load_check("store_merge back to back", 32'h88);
        store(32'h8c, 32'h55667788, 4'b1010);
        load_check("store_merge other word", 32'h84);
        load_check("store_merge later", 32'h8c);
    endtask

    task automatic dirty_evict_test();
        addr_t line0;
        int    wb_before;
        line0     = 32'hc0;
        wb_before = mem_model_inst.wb_count;
        store(line0 + 4, 32'hdeadbeef, 4'b1111);
        load_check("dirty_evict second line", line0 + STRIDE);
        load_check("dirty_evict third line", line0 + 2 * STRIDE);
        check("dirty_evict writeback count", wb_before + 1, mem_model_inst.wb_count);
        check("dirty_evict writeback addr", line0, mem_model_inst.last_wb_addr);
        for (int i = 0; i < BANKS; i++) begin
            check("dirty_evict writeback data", shadow_word(line0 + 4 * i),
                  mem_model_inst.last_wb_data[3'(i)]);
        end
        load_check("dirty_evict reload", line0 + 4);
    endtask

    task automatic lru_test();
        addr_t line_a;
        line_a = 32'h100;
        load_check("lru A", line_a);
        load_check("lru B", line_a + STRIDE);
        load_check("lru A again", line_a);
        check("lru A again miss flag", 0, last_miss);
        load_check("lru C", line_a + 2 * STRIDE);
        load_check("lru A kept", line_a);
        check("lru A kept miss flag", 0, last_miss);
        load_check("lru B evicted", line_a + STRIDE);
        check("lru B evicted miss flag", 1, last_miss);
    endtask

    task automatic uncached_test();
        addr_t x;
        int    rd_before;
        int    wb_before;
        x = 32'h204;
        load_check("uncached cached copy", x);  // leaves a copy that goes stale
        rd_before = mem_model_inst.rd_count;
        wb_before = mem_model_inst.wb_count;
        issue(1'b1, x, 32'h13579bdf, 4'b0110, 1'b1);
        issue(1'b0, x, '0, 4'h0, 1'b1);
        check("uncached load", shadow_word(x), last_rdata);
        check("uncached store in memory", shadow_word(x), model_word(x));
        check("uncached line reads", rd_before, mem_model_inst.rd_count);
        check("uncached line writes", wb_before, mem_model_inst.wb_count);
    endtask

    task automatic random_mix_test();
        addr_t addr;
        for (int n = 0; n < 200; n++) begin
            addr = ($urandom % 4) * STRIDE + ($urandom % 4) * 32 + ($urandom % 8) * 4;
            if ($urandom % 2) begin
                store(addr, $urandom, 4'($urandom));
            end else begin
                load_check("random_mix load", addr);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h497945ee));
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        reset      = 1'b1;
        req        = '0;
        uncache    = 1'b0;
        for (int i = 0; i < 16384; i++) begin
            shadow[14'(i)]             = 8'($urandom);
            mem_model_inst.mem[14'(i)] = shadow[14'(i)];
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        load_miss_hit_test();
        store_merge_test();
        dirty_evict_test();
        lru_test();
        uncached_test();
        random_mix_test();
        $display("sets %0d: checks %0d, errors %0d, timeouts %0d",
                 NUM_SETS, n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
dcache_pkg.sv
bram_sdp.sv
dcache_way.sv
dcache_ctrl.sv
dcache_top.sv
dcache_assert.sv
tb_mem_model.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# builds and runs the testbench with 128 and 64 sets, one shared log
cd "$(dirname "$0")" || exit 1
rm -f run.log
for sets in 128 64; do
    verilator --binary --timing --assert --top-module tb_dcache -GNUM_SETS=$sets \
        --Mdir obj_$sets -f sources.f \
        && ./obj_$sets/Vtb_dcache >> run.log 2>&1 \
        || echo "%Error: build or run failed with $sets sets" >> run.log
done
grep -q -e '\*\*\* FAILED \*\*\*' -e '%Error' run.log \
    && { echo "simulation failed, see run.log"; exit 1; } \
    || echo "simulation passed"
